//--- sim.f
src/heapConfigPkg.sv
src/heapCommandPkg.sv
src/heapCommandStage.sv
src/arrayBookkeeper.sv
src/elementStore.sv
src/heapResponse.sv
src/heapMemory.sv
tb/heapMemory_props.sv
tb/heapMemoryTb.sv

//--- src/arrayBookkeeper.sv
// Allocation and size bookkeeping of the array heap
// Decides legality of each registered request and drives the element store
// State updates at the same edge that the response stage registers

`timescale 1ns/1ps

module arrayBookkeeper #(
  parameter int addressBits = 2,                             // Bits in an array number
  parameter int indexBits   = 2,                             // Bits in an element index
  parameter int dataBits    = 12                             // Element width
) (
  input  logic                        clock,
  input  logic                        reset,
  input  heapCommandPkg::heapAction_t cmdAction,
  input  logic [addressBits-1:0]      cmdArray,
  input  logic [indexBits-1:0]        cmdIndex,
  input  logic [dataBits-1:0]         cmdData,
  output logic                        storeEnable,           // Legal element access
  output logic [indexBits-1:0]        storeIndex,            // Element to touch
  output heapCommandPkg::heapError_t  bookError,
  output logic [dataBits-1:0]         bookValue,             // Array number or size
  output logic                        fromStore,             // Result comes from the store
  output logic                        hasResult              // Action yields a value
);

  import heapCommandPkg::*;

  localparam int arrays      = 1 << addressBits;             // Arrays in the heap
  localparam int arrayLength = 1 << indexBits;               // Elements per array

  //--------------------------------------------------
  // Allocation state
  //--------------------------------------------------
  logic [addressBits-1:0] freedStack [arrays];               // LIFO of freed arrays
  logic [addressBits:0]   freedTop;                          // Entries on the stack
  logic [addressBits:0]   usedCount;                         // Fresh arrays handed out
  logic [arrays-1:0]      allocated;                         // One flag per array
  logic [indexBits:0]     sizes [arrays];                    // Current size per array

  logic [indexBits:0]     curSize;                           // Size of the addressed array
  logic [addressBits-1:0] allocNumber;                       // Array that Alloc hands out
  heapError_t             accessError;                       // Handed out and allocated
  heapError_t             boundedError;                      // Plus index below size
  logic                   touchesElement;                    // Action needs the store

  assign curSize = sizes[cmdArray];

  // Legality checks in priority order
  always_comb begin
    if ({1'b0, cmdArray} >= usedCount) begin
      accessError = errNotAllocated;
    end else if (!allocated[cmdArray]) begin
      accessError = errArrayFreed;
    end else begin
      accessError = errNone;
    end
    if (accessError == errNone && {1'b0, cmdIndex} >= curSize) begin
      boundedError = errOutOfBounds;
    end else begin
      boundedError = accessError;
    end
  end

  // Most recently freed array first, then a fresh one
  always_comb begin
    if (freedTop != '0) begin
      allocNumber = freedStack[freedTop[addressBits-1:0] - 1'b1];
    end else begin
      allocNumber = usedCount[addressBits-1:0];
    end
  end

  //--------------------------------------------------
  // Request decode
  //--------------------------------------------------
  always_comb begin
    bookError      = errNone;
    bookValue      = '0;
    fromStore      = 1'b0;
    hasResult      = 1'b0;
    touchesElement = 1'b0;
    storeIndex     = cmdIndex;                               // Plain element access
    case (cmdAction)
      actAlloc: begin
        if (freedTop == '0 && usedCount == arrays) bookError = errOutOfMemory;
        bookValue = dataBits'(allocNumber);
        hasResult = 1'b1;
      end
      actFree: begin
        bookError = accessError;
      end
      actSize: begin
        bookError = accessError;
        bookValue = dataBits'(curSize);
        hasResult = 1'b1;
      end
      actResize: begin
        bookError = accessError;
        if (accessError == errNone && cmdData > arrayLength) bookError = errTooLarge;
      end
      actWrite: begin
        bookError      = accessError;
        touchesElement = 1'b1;
        fromStore      = 1'b1;
        hasResult      = 1'b1;
      end
      actRead, actAdd, actAddAfter, actSubtract, actOr, actXor, actAnd: begin
        bookError      = boundedError;                       // Index must be inside
        touchesElement = 1'b1;
        fromStore      = 1'b1;
        hasResult      = 1'b1;
      end
      actPush: begin
        bookError = accessError;
        if (accessError == errNone && curSize == arrayLength) bookError = errArrayFull;
        storeIndex     = curSize[indexBits-1:0];             // Slot after the last
        touchesElement = 1'b1;
        fromStore      = 1'b1;
        hasResult      = 1'b1;
      end
      actPop: begin
        bookError = accessError;
        if (accessError == errNone && curSize == '0) bookError = errArrayEmpty;
        storeIndex     = indexBits'(curSize - 1'b1);         // Last element
        touchesElement = 1'b1;
        fromStore      = 1'b1;
        hasResult      = 1'b1;
      end
      default: begin
      end
    endcase
    storeEnable = touchesElement && bookError == errNone;
  end

  //--------------------------------------------------
  // State update
  //--------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset || cmdAction == actReset) begin
      freedTop  <= '0;
      usedCount <= '0;
      allocated <= '0;                                       // Every array free
      for (int i = 0; i < arrays; i++) begin
        sizes[i] <= '0;
      end
    end else if (bookError == errNone) begin
      case (cmdAction)
        actAlloc: begin
          if (freedTop != '0) freedTop <= freedTop - 1'b1;  // Reuse a freed array
          else usedCount <= usedCount + 1'b1;                // Take a fresh one
          allocated[allocNumber] <= 1'b1;
          sizes[allocNumber]     <= '0;                      // Starts empty
        end
        actFree: begin
          freedStack[freedTop[addressBits-1:0]] <= cmdArray;
          freedTop            <= freedTop + 1'b1;
          allocated[cmdArray] <= 1'b0;
        end
        actWrite: begin
          if ({1'b0, cmdIndex} >= curSize) sizes[cmdArray] <= {1'b0, cmdIndex} + 1'b1;
        end
        actPush:   sizes[cmdArray] <= curSize + 1'b1;
        actPop:    sizes[cmdArray] <= curSize - 1'b1;
        actResize: sizes[cmdArray] <= cmdData[indexBits:0];
        default: begin
        end
      endcase
    end
  end

endmodule

//--- src/elementStore.sv
// Element memory of the array heap, one row per array
// Performs the element access and arithmetic that the bookkeeper enables

`timescale 1ns/1ps

module elementStore #(
  parameter int addressBits = 2,                             // Bits in an array number
  parameter int indexBits   = 2,                             // Bits in an element index
  parameter int dataBits    = 12                             // Element width
) (
  input  logic                        clock,
  input  heapCommandPkg::heapAction_t cmdAction,
  input  logic [addressBits-1:0]      cmdArray,
  input  logic [dataBits-1:0]         cmdData,               // Operand or value
  input  logic                        storeEnable,           // Access found legal
  input  logic [indexBits-1:0]        storeIndex,
  output logic [dataBits-1:0]         storeValue             // Result of the access
);

  import heapCommandPkg::*;

  localparam int arrays      = 1 << addressBits;
  localparam int arrayLength = 1 << indexBits;

  logic [dataBits-1:0] memory [arrays][arrayLength];         // Arrays in fixed rows
  logic [dataBits-1:0] oldValue;                             // Element before the access
  logic [dataBits-1:0] newValue;                             // Element after the access
  logic                writeBack;                            // Action changes the element

  assign oldValue = memory[cmdArray][storeIndex];

  //--------------------------------------------------
  // Element arithmetic, wrapping at dataBits
  //--------------------------------------------------
  always_comb begin
    newValue   = oldValue;
    writeBack  = 1'b1;
    storeValue = oldValue;
    case (cmdAction)
      actWrite, actPush: begin
        newValue   = cmdData;
        storeValue = cmdData;                                // Echo the stored value
      end
      actAdd: begin
        newValue   = oldValue + cmdData;
        storeValue = newValue;
      end
      actAddAfter: begin
        newValue   = oldValue + cmdData;                     // Old value returned
      end
      actSubtract: begin
        newValue   = oldValue - cmdData;
        storeValue = newValue;
      end
      actOr: begin
        newValue   = oldValue | cmdData;
        storeValue = newValue;
      end
      actXor: begin
        newValue   = oldValue ^ cmdData;
        storeValue = newValue;
      end
      actAnd: begin
        newValue   = oldValue & cmdData;
        storeValue = newValue;
      end
      default: begin
        writeBack  = 1'b0;                                   // Read, Pop and the rest
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (storeEnable && writeBack) begin
      memory[cmdArray][storeIndex] <= newValue;
    end
  end

endmodule

//--- src/heapCommandPkg.sv
// Action codes and error kinds of the array heap
// Shared by every pipeline stage and by the testbench

package heapCommandPkg;

  //--------------------------------------------------
  // Action codes
  //--------------------------------------------------
  typedef enum logic [7:0] {
    actIdle     = 8'd0,                                      // No request
    actReset    = 8'd1,                                      // Free every array
    actWrite    = 8'd2,                                      // Write an element
    actRead     = 8'd3,                                      // Read an element
    actSize     = 8'd4,                                      // Current size of an array
    actPush     = 8'd14,                                     // Append at the end
    actPop      = 8'd15,                                     // Remove from the end
    actResize   = 8'd17,                                     // Set the size directly
    actAlloc    = 8'd18,                                     // Hand out an array
    actFree     = 8'd19,                                     // Give an array back
    actAdd      = 8'd20,                                     // Add, return new value
    actAddAfter = 8'd21,                                     // Add, return old value
    actSubtract = 8'd22,                                     // Subtract, return new value
    actOr       = 8'd28,                                     // Bitwise or
    actXor      = 8'd29,                                     // Bitwise xor
    actAnd      = 8'd30                                      // Bitwise and
  } heapAction_t;

  //--------------------------------------------------
  // Error kinds
  //--------------------------------------------------
  typedef enum logic [3:0] {
    errNone,                                                 // Request succeeded
    errNotAllocated,                                         // Array never handed out
    errArrayFreed,                                           // Array given back
    errOutOfBounds,                                          // Index at or past the size
    errArrayFull,                                            // Push on a full array
    errArrayEmpty,                                           // Pop on an empty array
    errTooLarge,                                             // Resize past the array length
    errOutOfMemory                                           // No array left to hand out
  } heapError_t;

endpackage

//--- src/heapCommandStage.sv
// Input stage of the array heap
// Registers one request per clock; unknown action codes become idle

`timescale 1ns/1ps

module heapCommandStage #(
  parameter int addressBits = 2,                             // Bits in an array number
  parameter int indexBits   = 2,                             // Bits in an element index
  parameter int dataBits    = 12                             // Element width
) (
  input  logic                        clock,
  input  logic                        reset,
  input  heapCommandPkg::heapAction_t action,                // Requested action
  input  logic [addressBits-1:0]      array,                 // Array number
  input  logic [indexBits-1:0]        index,                 // Element index
  input  logic [dataBits-1:0]         dataIn,                // Operand or value
  output heapCommandPkg::heapAction_t cmdAction,             // Registered action
  output logic [addressBits-1:0]      cmdArray,
  output logic [indexBits-1:0]        cmdIndex,
  output logic [dataBits-1:0]         cmdData
);

  import heapCommandPkg::*;

  // Action register, the only control state here
  always_ff @(posedge clock) begin
    if (reset) begin
      cmdAction <= actIdle;                                  // Nothing in flight
    end else begin
      case (action)
        actReset, actWrite, actRead, actSize, actPush, actPop,
        actResize, actAlloc, actFree, actAdd, actAddAfter,
        actSubtract, actOr, actXor, actAnd: begin
          cmdAction <= action;                               // Known code
        end
        default: begin
          cmdAction <= actIdle;                              // Unknown code dropped
        end
      endcase
    end
  end

  // Operands, only meaningful alongside a known action
  always_ff @(posedge clock) begin
    cmdArray <= array;
    cmdIndex <= index;
    cmdData  <= dataIn;
  end

endmodule

//--- src/heapConfigPkg.sv
// Default geometry of the array heap
// The top level takes these as its parameter defaults and passes them down
// Derived sizes are here for the testbench reference model

package heapConfigPkg;

  //--------------------------------------------------
  // Heap geometry
  //--------------------------------------------------
  localparam int defaultAddressBits = 2;                     // Four arrays
  localparam int defaultIndexBits   = 2;                     // Arrays four long
  localparam int defaultDataBits    = 12;                    // Element width

  //--------------------------------------------------
  // Derived sizes
  //--------------------------------------------------
  localparam int defaultArrays      = 1 << defaultAddressBits; // Arrays in the heap
  localparam int defaultArrayLength = 1 << defaultIndexBits;   // Elements per array

endpackage

//--- src/heapMemory.sv
// Top level of the array heap
// Command stage, bookkeeper, element store and response stage in a two-cycle pipeline
// Geometry defaults come from the configuration package

`timescale 1ns/1ps

module heapMemory #(
  parameter int addressBits = heapConfigPkg::defaultAddressBits,
  parameter int indexBits   = heapConfigPkg::defaultIndexBits,
  parameter int dataBits    = heapConfigPkg::defaultDataBits
) (
  input  logic                        clock,
  input  logic                        reset,
  input  heapCommandPkg::heapAction_t action,                // Request, idle when none
  input  logic [addressBits-1:0]      array,
  input  logic [indexBits-1:0]        index,
  input  logic [dataBits-1:0]         dataIn,
  output logic [dataBits-1:0]         dataOut,
  output heapCommandPkg::heapError_t  error,
  output logic                        done
);

  import heapCommandPkg::*;

  //--------------------------------------------------
  // Pipeline wires
  //--------------------------------------------------
  heapAction_t            cmdAction;                         // Registered request
  logic [addressBits-1:0] cmdArray;
  logic [indexBits-1:0]   cmdIndex;
  logic [dataBits-1:0]    cmdData;
  logic                   storeEnable;                       // Bookkeeper to store
  logic [indexBits-1:0]   storeIndex;
  heapError_t             bookError;                         // Bookkeeper to response
  logic [dataBits-1:0]    bookValue;
  logic                   fromStore;
  logic                   hasResult;
  logic [dataBits-1:0]    storeValue;                        // Store to response

  heapCommandStage #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    commandStage (
      .clock(clock), .reset(reset), .action(action), .array(array), .index(index),
      .dataIn(dataIn), .cmdAction(cmdAction), .cmdArray(cmdArray), .cmdIndex(cmdIndex),
      .cmdData(cmdData));

  arrayBookkeeper #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    bookkeeper (
      .clock(clock), .reset(reset), .cmdAction(cmdAction), .cmdArray(cmdArray),
      .cmdIndex(cmdIndex), .cmdData(cmdData), .storeEnable(storeEnable),
      .storeIndex(storeIndex), .bookError(bookError), .bookValue(bookValue),
      .fromStore(fromStore), .hasResult(hasResult));

  elementStore #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    store (
      .clock(clock), .cmdAction(cmdAction), .cmdArray(cmdArray), .cmdData(cmdData),
      .storeEnable(storeEnable), .storeIndex(storeIndex), .storeValue(storeValue));

  heapResponse #(.dataBits(dataBits))
    response (
      .clock(clock), .reset(reset), .cmdAction(cmdAction), .bookError(bookError),
      .bookValue(bookValue), .fromStore(fromStore), .hasResult(hasResult),
      .storeValue(storeValue), .dataOut(dataOut), .error(error), .done(done));

endmodule

//--- src/heapResponse.sv
// Output stage of the array heap
// Registers result value, error kind and a one-cycle done pulse

`timescale 1ns/1ps

module heapResponse #(
  parameter int dataBits = 12                                // Element width
) (
  input  logic                        clock,
  input  logic                        reset,
  input  heapCommandPkg::heapAction_t cmdAction,
  input  heapCommandPkg::heapError_t  bookError,
  input  logic [dataBits-1:0]         bookValue,             // Array number or size
  input  logic                        fromStore,             // Pick the store result
  input  logic                        hasResult,
  input  logic [dataBits-1:0]         storeValue,
  output logic [dataBits-1:0]         dataOut,               // Holds when no result
  output heapCommandPkg::heapError_t  error,
  output logic                        done                   // One pulse per request
);

  import heapCommandPkg::*;

  always_ff @(posedge clock) begin
    if (reset) begin
      dataOut <= '0;
      error   <= errNone;
      done    <= 1'b0;
    end else begin
      error <= bookError;
      done  <= cmdAction != actIdle;                         // Every known request answers
      if (hasResult && bookError == errNone) begin
        dataOut <= fromStore ? storeValue : bookValue;
      end
    end
  end

endmodule

//--- tb/heapMemoryTb.sv
// Directed testbench for the array heap
// A reference model predicts every response; a monitor checks the done pulses in order

`timescale 1ns/1ps

module heapMemoryTb;

  import heapConfigPkg::*;
  import heapCommandPkg::*;

  localparam int addressBits     = defaultAddressBits;
  localparam int indexBits       = defaultIndexBits;
  localparam int dataBits        = defaultDataBits;
  localparam int plannedRequests = 80;                       // Upper bound over all tests
  localparam int watchdogCycles  = plannedRequests * 10 + 100;

  logic                   clock;
  logic                   reset;
  heapAction_t            action;
  logic [addressBits-1:0] array;
  logic [indexBits-1:0]   index;
  logic [dataBits-1:0]    dataIn;
  logic [dataBits-1:0]    dataOut;
  heapError_t             error;
  logic                   done;

  int seed = 32'h6854;                                       // Fixed random seed
  int cycle = 0;                                             // Rising edges so far
  int dataErrors = 0;
  int kindErrors = 0;
  int otherErrors = 0;

  //--------------------------------------------------
  // Reference model
  //--------------------------------------------------
  logic [dataBits-1:0] modelMem [defaultArrays][defaultArrayLength];
  logic                known [defaultArrays][defaultArrayLength];  // Element written once
  int                  modelSize [defaultArrays];
  logic                modelAlloc [defaultArrays];
  int                  handedOut;                            // Fresh arrays given out
  int                  freedStack [$];                       // Most recent at the back
  logic [dataBits-1:0] lastData;                             // Value dataOut should hold
  logic [dataBits-1:0] expData [$];                          // Expected responses in order
  heapError_t          expKind [$];
  int                  expCycle [$];

  heapMemory #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits)) UUT (
    .clock(clock), .reset(reset), .action(action), .array(array), .index(index),
    .dataIn(dataIn), .dataOut(dataOut), .error(error), .done(done));

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;                              // 20 ns period
  end

  always @(posedge clock) cycle <= cycle + 1;

  function automatic logic [dataBits-1:0] randomValue();
    return $random(seed);
  endfunction

  function automatic heapError_t accessKind(int arr);
    if (arr >= handedOut) return errNotAllocated;            // Never handed out
    if (!modelAlloc[arr]) return errArrayFreed;
    return errNone;
  endfunction

  // Predicts one response and advances the model
  task automatic predict(heapAction_t act, int arr, int idx, logic [dataBits-1:0] data);
    heapError_t          kind;
    logic [dataBits-1:0] value;
    logic [dataBits-1:0] old;
    logic                result;
    kind   = accessKind(arr);
    value  = lastData;
    result = 1'b1;
    case (act)
      actReset: begin
        kind      = errNone;
        result    = 1'b0;
        handedOut = 0;
        freedStack.delete();
        for (int i = 0; i < defaultArrays; i++) begin
          modelAlloc[i] = 1'b0;
          modelSize[i]  = 0;
        end
      end
      actAlloc: begin
        kind = errNone;
        if (freedStack.size() == 0 && handedOut == defaultArrays) begin
          kind = errOutOfMemory;
        end else begin
          if (freedStack.size() != 0) begin
            value = freedStack.pop_back();                   // Reuse latest freed
          end else begin
            value = handedOut;
            handedOut++;
          end
          modelAlloc[value] = 1'b1;
          modelSize[value]  = 0;
        end
      end
      actFree: begin
        result = 1'b0;
        if (kind == errNone) begin
          modelAlloc[arr] = 1'b0;
          freedStack.push_back(arr);
        end
      end
      actSize: value = modelSize[arr];
      actResize: begin
        result = 1'b0;
        if (kind == errNone && data > defaultArrayLength) kind = errTooLarge;
        else if (kind == errNone) modelSize[arr] = data;
      end
      actWrite: begin
        value = data;
        if (kind == errNone) begin
          modelMem[arr][idx] = data;
          known[arr][idx]    = 1'b1;
          if (idx >= modelSize[arr]) modelSize[arr] = idx + 1;  // Grows the array
        end
      end
      actPush: begin
        value = data;
        if (kind == errNone && modelSize[arr] == defaultArrayLength) kind = errArrayFull;
        if (kind == errNone) begin
          modelMem[arr][modelSize[arr]] = data;
          known[arr][modelSize[arr]]    = 1'b1;
          modelSize[arr]++;
        end
      end
      actPop: begin
        if (kind == errNone && modelSize[arr] == 0) kind = errArrayEmpty;
        if (kind == errNone) begin
          modelSize[arr]--;
          value = modelMem[arr][modelSize[arr]];
        end
      end
      actRead, actAdd, actAddAfter, actSubtract, actOr, actXor, actAnd: begin
        if (kind == errNone && idx >= modelSize[arr]) kind = errOutOfBounds;
        if (kind == errNone) begin
          old = modelMem[arr][idx];
          case (act)
            actAdd, actAddAfter: value = old + data;         // Wraps at dataBits
            actSubtract:         value = old - data;
            actOr:               value = old | data;
            actXor:              value = old ^ data;
            actAnd:              value = old & data;
            default:             value = old;
          endcase
          modelMem[arr][idx] = value;
          if (act == actAddAfter) value = old;               // Old value returned
        end
      end
      default: result = 1'b0;
    endcase
    if (result && kind == errNone) lastData = value;         // Otherwise dataOut holds
    expData.push_back(lastData);
    expKind.push_back(kind);
    expCycle.push_back(cycle + 2);                           // Sampled next edge, answered after
  endtask

  //--------------------------------------------------
  // Driving and checking
  //--------------------------------------------------
  task automatic issue(heapAction_t act, int arr, int idx, logic [dataBits-1:0] data);
    @(posedge clock);
    #1;
    action = act;
    array  = arr;
    index  = idx;
    dataIn = data;
    predict(act, arr, idx, data);
  endtask

  // Ends a burst and waits for every outstanding done pulse
  task automatic drain();
    int waited;
    @(posedge clock);
    #1;
    action = actIdle;
    waited = 0;
    while (expKind.size() != 0 && waited < 10) begin
      @(posedge clock);                                      // Monitor pops at negedge
      waited++;
    end
    if (expKind.size() != 0) begin
      $display("No done pulse for %0d requests by %0t", expKind.size(), $time);
      otherErrors++;
      expData.delete();
      expKind.delete();
      expCycle.delete();
    end
  endtask

  task automatic request(heapAction_t act, int arr, int idx, logic [dataBits-1:0] data);
    issue(act, arr, idx, data);
    drain();
  endtask

  task automatic checkData(logic [dataBits-1:0] expected, logic [dataBits-1:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t dataOut expected %h got %h", $time, expected, actual);
      dataErrors++;
    end
  endtask

  task automatic checkKind(heapError_t expected, heapError_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t error expected %s got %s", $time, expected.name(), actual.name());
      kindErrors++;
    end
  endtask

  // Outputs left by reset, before any request
  task automatic checkResetState();
    if (done !== 1'b0) begin
      $display("done not low right after reset at %0t", $time);
      otherErrors++;
    end
    checkData('0, dataOut);
    checkKind(errNone, error);
  endtask

  // Outputs settle after the rising edge
  always @(negedge clock) begin
    if (done) begin
      if (expKind.size() == 0) begin
        $display("Done pulse at %0t with no request outstanding", $time);
        otherErrors++;
      end else begin
        checkData(expData.pop_front(), dataOut);
        checkKind(expKind.pop_front(), error);
        if (expCycle.pop_front() != cycle) begin
          $display("Done pulse at cycle %0d came at the wrong cycle", cycle);
          otherErrors++;
        end
      end
    end
  end

  //--------------------------------------------------
  // Directed tests
  //--------------------------------------------------
  task automatic testAllocation();
    for (int i = 0; i <= defaultArrays; i++) begin
      request(actAlloc, 0, 0, 0);                            // Last one runs out
    end
    request(actFree, 2, 0, 0);
    request(actFree, 1, 0, 0);
    request(actAlloc, 0, 0, 0);
    request(actAlloc, 0, 0, 0);
  endtask

  task automatic testAccessChecks();
    request(actFree, 3, 0, 0);
    request(actRead, 3, 0, 0);                               // Freed array
    request(actFree, 3, 0, 0);                               // Double free
    request(actReset, 0, 0, 0);
    request(actAlloc, 0, 0, 0);
    request(actWrite, 0, 1, randomValue());
    request(actRead, 2, 0, 0);                               // Never handed out
    request(actRead, 0, 2, 0);                               // At the size
    request(actRead, 0, defaultArrayLength - 1, 0);
  endtask

  task automatic testWriteReadSize();
    int idx;
    request(actReset, 0, 0, 0);
    request(actAlloc, 0, 0, 0);
    for (int i = 0; i < 4; i++) begin
      idx = randomValue() % defaultArrayLength;
      request(actWrite, 0, idx, randomValue());
    end
    request(actSize, 0, 0, 0);
    for (int i = 0; i < modelSize[0]; i++) begin
      if (known[0][i]) request(actRead, 0, i, 0);
    end
    request(actResize, 0, 0, defaultArrayLength);
    request(actSize, 0, 0, 0);
    request(actResize, 0, 0, defaultArrayLength + 1);        // One past the length
    request(actSize, 0, 0, 0);
  endtask

  task automatic testStack();
    request(actReset, 0, 0, 0);
    request(actAlloc, 0, 0, 0);
    for (int i = 0; i <= defaultArrayLength; i++) begin
      request(actPush, 0, 0, randomValue());                 // Last push overflows
    end
    for (int i = 0; i <= defaultArrayLength; i++) begin
      request(actPop, 0, 0, 0);                              // Last pop underflows
    end
  endtask

  task automatic testArithmetic();
    request(actReset, 0, 0, 0);
    request(actAlloc, 0, 0, 0);
    for (int i = 0; i < defaultArrayLength; i++) begin
      request(actWrite, 0, i, randomValue());
    end
    request(actAdd, 0, 0, randomValue());
    request(actAdd, 0, 0, '1);                               // Forces a wrap
    request(actSubtract, 0, 1 % defaultArrayLength, randomValue());
    request(actAnd, 0, 2 % defaultArrayLength, randomValue());
    request(actOr, 0, 3 % defaultArrayLength, randomValue());
    request(actXor, 0, 0, randomValue());
    request(actAddAfter, 0, 1 % defaultArrayLength, randomValue());
    request(actRead, 0, 1 % defaultArrayLength, 0);          // Shows the sum
  endtask

  // Back to back, each one sees the state left by the one before
  task automatic testPipelining();
    issue(actReset, 0, 0, 0);
    issue(actAlloc, 0, 0, 0);
    issue(actWrite, 0, 0, randomValue());
    issue(actAdd, 0, 0, randomValue());
    issue(actPush, 0, 0, randomValue());
    issue(actSize, 0, 0, 0);
    issue(actPop, 0, 0, 0);
    issue(actRead, 0, 0, 0);
    issue(actFree, 0, 0, 0);
    issue(actRead, 0, 0, 0);
    drain();
  endtask

  initial begin
    reset  = 1'b1;
    action = actIdle;
    array  = '0;
    index  = '0;
    dataIn = '0;
    handedOut = 0;
    lastData  = '0;                                          // dataOut after reset
    for (int a = 0; a < defaultArrays; a++) begin
      modelAlloc[a] = 1'b0;
      modelSize[a]  = 0;
      for (int e = 0; e < defaultArrayLength; e++) known[a][e] = 1'b0;
    end
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    checkResetState();
    testAllocation();
    testAccessChecks();
    testWriteReadSize();
    testStack();
    testArithmetic();
    testPipelining();
    repeat (3) @(posedge clock);                             // Catch stray pulses
    $display("Error counts: dataOut %0d, error kind %0d, other %0d",
             dataErrors, kindErrors, otherErrors);
    if (dataErrors + kindErrors + otherErrors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdogCycles * 20);
    $display("Run did not finish within %0d cycles", watchdogCycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- tb/heapMemory_props.sv
// Concurrent checks on the response timing of the array heap
// Bound to every heapMemory instance by the bind at the end

`timescale 1ns/1ps

module heapMemory_props (
  input logic                        clock,
  input logic                        reset,
  input heapCommandPkg::heapAction_t action,                 // Raw request at the top
  input heapCommandPkg::heapError_t  error,
  input logic                        done
);

  import heapCommandPkg::*;

  // Every request answers two clocks later
  doneFollowsRequest: assert property (@(posedge clock) disable iff (reset)
    action != actIdle |-> ##2 done)
    else $error("done missing two cycles after a request");

  // An idle slot yields no done, so a pulse cannot stretch
  doneNotStretched: assert property (@(posedge clock) disable iff (reset)
    action == actIdle |-> ##2 !done)
    else $error("done high without a request two cycles before");

  quietAfterReset: assert property (@(posedge clock)
    $fell(reset) |-> !done && error == errNone)
    else $error("done or error active right after reset");

endmodule

bind heapMemory heapMemory_props timingChecks (
  .clock(clock), .reset(reset), .action(action), .error(error), .done(done));
